//--- hdl/wb_pkg.sv
`default_nettype none

package wb_pkg;

    // Datapath widths
    localparam int XLEN      = 32;
    localparam int ADDR_W    = 32;
    localparam int REG_NUM_W = 5;
    localparam int IID_W     = 8;
    localparam int WB_SEL_W  = 2;

    typedef logic [XLEN-1:0]      xlen_t;     // Register value
    typedef logic [ADDR_W-1:0]    addr_t;     // Program counter
    typedef logic [REG_NUM_W-1:0] reg_addr_t; // Register number
    typedef logic [IID_W-1:0]     iid_t;      // Instruction id, wraps
    typedef logic [WB_SEL_W-1:0]  wb_sel_t;   // Write-back source

    // Write-back source codes
    localparam wb_sel_t WB_ALU = 2'd0;
    localparam wb_sel_t WB_MEM = 2'd1;
    localparam wb_sel_t WB_PC  = 2'd2; // Return address for jal/jalr
    localparam wb_sel_t WB_CSR = 2'd3;

    // Return address offset, one instruction past pc
    localparam xlen_t PC_STEP = 32'd4;

    // Register file geometry
    localparam int        NUM_REGS = 2 ** REG_NUM_W;
    localparam reg_addr_t REG_ZERO = 5'd0; // x0, hardwired zero
    localparam reg_addr_t REG_SP   = 5'd2; // x2, stack pointer

endpackage

`default_nettype wire

//--- hdl/retire_if.sv
`timescale 1ns/1ps
`default_nettype none

interface retire_if;

    import wb_pkg::*;

    logic      retire; // One cycle per retired instruction
    logic      wen;
    reg_addr_t waddr;
    xlen_t     wdata;

    modport src (
        output retire,
        output wen,
        output waddr,
        output wdata
    );

    modport rf (
        input retire,
        input wen,
        input waddr,
        input wdata
    );

    modport cnt (
        input retire
    );

endinterface

`default_nettype wire

//--- hdl/writeback_stage.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
    input  wire logic               clk,
    input  wire logic               rst,

    // Bundle from the memory stage
    input  wire logic               wb_valid,
    input  wire wb_pkg::addr_t      wb_pc,
    input  wire wb_pkg::iid_t       wb_inst_id,
    input  wire wb_pkg::wb_sel_t    wb_sel,
    input  wire logic               rf_wen,
    input  wire wb_pkg::reg_addr_t  wb_addr,
    input  wire wb_pkg::xlen_t      alu_out,
    input  wire wb_pkg::xlen_t      mem_rdata,
    input  wire wb_pkg::xlen_t      csr_rdata,

    // Forwarding value and retire request
    output wb_pkg::xlen_t           wdata,
    retire_if.src                   ret
);

    import wb_pkg::*;

    xlen_t ret_addr;   // pc + 4 for link writes
    xlen_t sel_data;

    iid_t  saved_id;   // Id of the last valid bundle
    logic  id_seen;    // Cleared by reset, set by the first valid bundle
    logic  id_changed;
    logic  new_inst;

    // Write-back source mux

    assign ret_addr = xlen_t'(wb_pc) + PC_STEP;

    always_comb begin
        case (wb_sel)
            WB_ALU:  sel_data = alu_out;
            WB_MEM:  sel_data = mem_rdata;
            WB_PC:   sel_data = ret_addr;
            WB_CSR:  sel_data = csr_rdata;
            default: sel_data = alu_out;
        endcase
    end

    assign wdata = sel_data; // Forwarded regardless of valid

    // Retire detection
    // A stalled memory stage repeats the bundle with the same id, so
    // only an id change (or the first bundle after reset) retires

    assign id_changed = (wb_inst_id != saved_id);
    assign new_inst   = wb_valid && (!id_seen || id_changed);

    always_ff @(posedge clk) begin
        if (rst) begin
            id_seen <= 1'b0;
        end else if (wb_valid) begin
            id_seen <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_valid) begin
            saved_id <= wb_inst_id; // Bubbles keep the old id
        end
    end

    // Request to register file and counter

    assign ret.retire = new_inst && !rst;
    assign ret.wen    = rf_wen;
    assign ret.waddr  = wb_addr;
    assign ret.wdata  = sel_data;

endmodule

`default_nettype wire

//--- hdl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file #(
    parameter wb_pkg::xlen_t STACK_INIT = 32'h0000_7500
) (
    input  wire logic               clk,
    input  wire logic               rst,

    retire_if.rf                    ret,

    // Decode stage read ports
    input  wire wb_pkg::reg_addr_t  raddr1,
    input  wire wb_pkg::reg_addr_t  raddr2,
    output wb_pkg::xlen_t           rdata1,
    output wb_pkg::xlen_t           rdata2
);

    import wb_pkg::*;

    xlen_t regs [NUM_REGS];
    logic  wr_en;

    // x0 is never written
    assign wr_en = ret.retire && ret.wen && (ret.waddr != REG_ZERO);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                if (reg_addr_t'(i) == REG_SP) begin
                    regs[i] <= STACK_INIT; // Initial stack pointer
                end else begin
                    regs[i] <= '0;
                end
            end
        end else if (wr_en) begin
            regs[ret.waddr] <= ret.wdata;
        end
    end

    // Reads see the stored array only, the pipeline forwards wb_wdata
    always_comb begin
        if (raddr1 == REG_ZERO) begin
            rdata1 = '0;
        end else begin
            rdata1 = regs[raddr1];
        end
    end

    always_comb begin
        if (raddr2 == REG_ZERO) begin
            rdata2 = '0;
        end else begin
            rdata2 = regs[raddr2];
        end
    end

endmodule

`default_nettype wire

//--- hdl/retire_counter.sv
`timescale 1ns/1ps
`default_nettype none

module retire_counter #(
    parameter int COUNT_W = 64
) (
    input  wire logic           clk,
    input  wire logic           rst,

    retire_if.cnt               ret,

    output logic [COUNT_W-1:0]  count
);

    logic [COUNT_W-1:0] count_q;
    logic [COUNT_W-1:0] count_inc;

    // Wraps at full width like minstret
    assign count_inc = count_q + COUNT_W'(1);

    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= '0;
        end else if (ret.retire) begin
            count_q <= count_inc;
        end
    end

    assign count = count_q;

endmodule

`default_nettype wire

//--- hdl/wb_top.sv
`timescale 1ns/1ps
`default_nettype none

module wb_top #(
    parameter wb_pkg::xlen_t STACK_INIT = 32'h0000_7500,
    parameter int            COUNT_W    = 64
) (
    input  wire logic               clk,
    input  wire logic               rst,

    // Bundle from the memory stage
    input  wire logic               wb_valid,
    input  wire wb_pkg::addr_t      wb_pc,
    input  wire wb_pkg::iid_t       wb_inst_id,
    input  wire wb_pkg::wb_sel_t    wb_sel,
    input  wire logic               rf_wen,
    input  wire wb_pkg::reg_addr_t  wb_addr,
    input  wire wb_pkg::xlen_t      alu_out,
    input  wire wb_pkg::xlen_t      mem_rdata,
    input  wire wb_pkg::xlen_t      csr_rdata,

    // Decode stage read ports
    input  wire wb_pkg::reg_addr_t  raddr1,
    input  wire wb_pkg::reg_addr_t  raddr2,

    output wb_pkg::xlen_t           wb_wdata,
    output wb_pkg::xlen_t           rs1_data,
    output wb_pkg::xlen_t           rs2_data,
    output logic [COUNT_W-1:0]      retire_count
);

    retire_if u_ret ();

    writeback_stage u_wb (
        .clk        (clk),
        .rst        (rst),
        .wb_valid   (wb_valid),
        .wb_pc      (wb_pc),
        .wb_inst_id (wb_inst_id),
        .wb_sel     (wb_sel),
        .rf_wen     (rf_wen),
        .wb_addr    (wb_addr),
        .alu_out    (alu_out),
        .mem_rdata  (mem_rdata),
        .csr_rdata  (csr_rdata),
        .wdata      (wb_wdata),
        .ret        (u_ret.src)
    );

    reg_file #(
        .STACK_INIT (STACK_INIT)
    ) u_rf (
        .clk        (clk),
        .rst        (rst),
        .ret        (u_ret.rf),
        .raddr1     (raddr1),
        .raddr2     (raddr2),
        .rdata1     (rs1_data),
        .rdata2     (rs2_data)
    );

    retire_counter #(
        .COUNT_W    (COUNT_W)
    ) u_cnt (
        .clk        (clk),
        .rst        (rst),
        .ret        (u_ret.cnt),
        .count      (retire_count)
    );

endmodule

`default_nettype wire

//--- dv/wb_assert.sv
`timescale 1ns/1ps
`default_nettype none

module wb_assert #(
    parameter int COUNT_W = 64
) (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               retire,
    input  wire wb_pkg::reg_addr_t  raddr1,
    input  wire wb_pkg::xlen_t      rs1_data,
    input  wire logic [COUNT_W-1:0] retire_count
);

    no_retire_in_reset: assert property (@(posedge clk) rst |-> !retire)
        else $error("retire strobe high while rst is asserted");

    // x0 is hardwired, reset or not
    x0_reads_zero: assert property (@(posedge clk) (raddr1 == '0) |-> (rs1_data == '0))
        else $error("rs1_data is not zero while raddr1 selects x0");

    count_steps: assert property (@(posedge clk) disable iff (rst)
        retire |=> (retire_count == $past(retire_count) + COUNT_W'(1)))
        else $error("retire_count did not advance by one after a retire");

    count_holds: assert property (@(posedge clk) disable iff (rst)
        !retire |=> (retire_count == $past(retire_count)))
        else $error("retire_count changed without a retire");

endmodule

bind wb_top wb_assert #(
    .COUNT_W      (COUNT_W)
) u_assert (
    .clk          (clk),
    .rst          (rst),
    .retire       (u_ret.retire),
    .raddr1       (raddr1),
    .rs1_data     (rs1_data),
    .retire_count (retire_count)
);

`default_nettype wire

//--- dv/wb_tb.sv
`timescale 1ns/1ps
`default_nettype none

module wb_tb;

    import wb_pkg::*;

    localparam int COUNT_W   = 64;
    localparam int MAX_LINES = 200; // Cycle limit for the stimulus file

    logic               clk;
    logic               rst;
    logic               wb_valid;
    addr_t              wb_pc;
    iid_t               wb_inst_id;
    wb_sel_t            wb_sel;
    logic               rf_wen;
    reg_addr_t          wb_addr;
    xlen_t              alu_out;
    xlen_t              mem_rdata;
    xlen_t              csr_rdata;
    reg_addr_t          raddr1;
    reg_addr_t          raddr2;
    xlen_t              wb_wdata;
    xlen_t              rs1_data;
    xlen_t              rs2_data;
    logic [COUNT_W-1:0] retire_count;

    // Reference model of the architectural state
    xlen_t              m_regs [NUM_REGS];
    iid_t               m_saved_id;
    logic               m_seen;
    logic [COUNT_W-1:0] m_count;

    // Fields of the current stimulus line
    logic               f_valid;
    iid_t               f_id;
    addr_t              f_pc;
    wb_sel_t            f_sel;
    logic               f_wen;
    reg_addr_t          f_addr;
    xlen_t              f_alu;
    xlen_t              f_mem;
    xlen_t              f_csr;
    reg_addr_t          f_ra1;
    reg_addr_t          f_ra2;
    xlen_t              f_exp;

    integer             seed;
    integer             fd;
    integer             n_items;
    int                 errors;
    int                 line_no;

    wb_top u_dut (
        .clk          (clk),
        .rst          (rst),
        .wb_valid     (wb_valid),
        .wb_pc        (wb_pc),
        .wb_inst_id   (wb_inst_id),
        .wb_sel       (wb_sel),
        .rf_wen       (rf_wen),
        .wb_addr      (wb_addr),
        .alu_out      (alu_out),
        .mem_rdata    (mem_rdata),
        .csr_rdata    (csr_rdata),
        .raddr1       (raddr1),
        .raddr2       (raddr2),
        .wb_wdata     (wb_wdata),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .retire_count (retire_count)
    );

    always #10 clk = ~clk;

    task automatic check_xlen(input string name, input xlen_t exp, input xlen_t act);
        if (act !== exp) begin
            errors++;
            $display("Error at time %0t: %s expected %h, actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input logic [COUNT_W-1:0] exp,
                               input logic [COUNT_W-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("Error at time %0t: %s expected %0d, actual %0d", $time, name, exp, act);
        end
    endtask

    function automatic xlen_t select_wb_value(wb_sel_t sel, addr_t pc, xlen_t alu,
                                              xlen_t mem, xlen_t csr);
        case (sel)
            WB_MEM:  return mem;
            WB_PC:   return pc + PC_STEP; // Link address
            WB_CSR:  return csr;
            default: return alu;
        endcase
    endfunction

    function automatic xlen_t read_model(reg_addr_t a);
        if (a == REG_ZERO) return '0;
        return m_regs[a];
    endfunction

    // Drives the f_* fields, checks before the next edge and advances the model
    task automatic run_cycle();
        xlen_t sel_val;
        logic  retire;
        @(posedge clk);
        #1;
        wb_valid   = f_valid;
        wb_inst_id = f_id;
        wb_pc      = f_pc;
        wb_sel     = f_sel;
        rf_wen     = f_wen;
        wb_addr    = f_addr;
        alu_out    = (f_sel == WB_ALU) ? f_alu : $random(seed); // Unselected sources get noise
        mem_rdata  = (f_sel == WB_MEM) ? f_mem : $random(seed);
        csr_rdata  = (f_sel == WB_CSR) ? f_csr : $random(seed);
        raddr1     = f_ra1;
        raddr2     = f_ra2;
        #17;
        sel_val = select_wb_value(wb_sel, wb_pc, alu_out, mem_rdata, csr_rdata);
        if (sel_val !== f_exp) begin
            errors++;
            $display("Stimulus line %0d lists a forwarding value that its selector cannot give",
                     line_no);
        end
        check_xlen("wb_wdata", f_exp, wb_wdata);
        check_xlen("rs1_data", read_model(f_ra1), rs1_data);
        check_xlen("rs2_data", read_model(f_ra2), rs2_data);
        check_count("retire_count", m_count, retire_count);
        retire = f_valid && (!m_seen || (f_id != m_saved_id));
        if (retire) begin
            m_count = m_count + COUNT_W'(1);
            if (f_wen && (f_addr != REG_ZERO)) m_regs[f_addr] = sel_val;
        end
        if (f_valid) begin
            m_saved_id = f_id; // A bubble keeps the old id
            m_seen     = 1'b1;
        end
    endtask

    // Bubble that reads two registers
    task automatic read_cycle(input reg_addr_t a1, input reg_addr_t a2);
        f_valid = 1'b0;
        f_id    = '0;
        f_pc    = '0;
        f_sel   = WB_ALU;
        f_wen   = 1'b0;
        f_addr  = REG_ZERO;
        f_alu   = '0;
        f_mem   = '0;
        f_csr   = '0;
        f_ra1   = a1;
        f_ra2   = a2;
        f_exp   = '0;
        run_cycle();
    endtask

    task automatic sweep_registers();
        for (int i = 0; i < NUM_REGS; i++) begin
            read_cycle(reg_addr_t'(i), reg_addr_t'(NUM_REGS - 1 - i));
        end
    endtask

    task automatic play_file();
        logic done;
        done    = 1'b0;
        line_no = 0;
        while (!done && line_no < MAX_LINES) begin
            n_items = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h", f_valid, f_id, f_pc,
                              f_sel, f_wen, f_addr, f_alu, f_mem, f_csr, f_ra1, f_ra2, f_exp);
            if (n_items == 12) begin
                line_no++;
                run_cycle();
            end else begin
                done = 1'b1;
            end
        end
        if (!done) begin
            errors++;
            $display("Stimulus file did not reach its end within %0d cycles", MAX_LINES);
        end else if (!$feof(fd)) begin
            errors++;
            $display("Stimulus line %0d could not be read as twelve hex fields", line_no + 1);
        end
    endtask

    initial begin
        seed       = 32'h39bf_996a;
        errors     = 0;
        line_no    = 0;
        clk        = 1'b0;
        rst        = 1'b1;
        wb_valid   = 1'b1; // Valid bundle during reset retires nothing
        wb_pc      = '0;
        wb_inst_id = '0;
        wb_sel     = WB_ALU;
        rf_wen     = 1'b1;
        wb_addr    = reg_addr_t'(1);
        alu_out    = 32'h0bad_0001;
        mem_rdata  = '0;
        csr_rdata  = '0;
        raddr1     = REG_ZERO;
        raddr2     = REG_ZERO;
        for (int i = 0; i < NUM_REGS; i++) begin
            m_regs[i] = '0;
        end
        m_regs[REG_SP] = 32'h0000_7500;
        m_saved_id     = '0;
        m_seen         = 1'b0;
        m_count        = '0;

        repeat (10) @(posedge clk);
        #1;
        rst      = 1'b0;
        wb_valid = 1'b0;
        rf_wen   = 1'b0;

        sweep_registers(); // Reset values

        fd = $fopen("dv/wb_stimulus.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the stimulus file dv/wb_stimulus.txt");
        end else begin
            play_file();
            $fclose(fd);
            sweep_registers(); // Final register state and count
        end

        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
hdl/wb_pkg.sv
hdl/retire_if.sv
hdl/writeback_stage.sv
hdl/reg_file.sv
hdl/retire_counter.sv
hdl/wb_top.sv
dv/wb_assert.sv
dv/wb_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the write-back testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module wb_tb -Mdir obj_dir -f project.f

sim_out=$(./obj_dir/Vwb_tb)
echo "$sim_out"

if grep -q "=== PASS ===" <<< "$sim_out"; then
    exit 0
fi
exit 1

//--- dv/wb_stimulus.txt
1 00 00001000 0 1 01 11111111 00000000 00000000 01 02 11111111
1 00 00001000 0 1 01 22222222 00000000 00000000 01 02 22222222
1 00 00001000 0 1 01 33333333 00000000 00000000 01 01 33333333
0 05 00001004 1 1 03 00000000 abcd0001 00000000 01 03 abcd0001
0 06 00001004 3 1 03 00000000 00000000 5a5a5a5a 03 00 5a5a5a5a
1 00 00001000 2 1 01 00000000 00000000 00000000 01 00 00001004
1 01 00001004 1 1 03 00000000 abcd0001 00000000 03 01 abcd0001
1 02 00001008 2 1 04 00000000 00000000 00000000 03 04 0000100c
1 03 0000100c 3 1 05 00000000 00000000 00000b00 04 05 00000b00
1 04 00001010 0 0 06 deadbeef 00000000 00000000 05 06 deadbeef
1 05 00001014 0 1 00 cafef00d 00000000 00000000 06 00 cafef00d
1 06 00001018 0 1 07 00000007 00000000 00000000 00 00 00000007
1 06 00001018 0 1 07 00000007 00000000 00000000 07 00 00000007
1 06 00001018 0 1 07 00000007 00000000 00000000 07 06 00000007
0 06 00001018 0 1 07 00000007 00000000 00000000 07 06 00000007
1 07 0000101c 1 1 02 00000000 00007ff0 00000000 02 07 00007ff0
1 08 00001020 0 1 08 00000008 00000000 00000000 02 07 00000008
1 09 00001024 1 1 09 00000000 00000009 00000000 08 02 00000009
1 0a 00001028 2 1 0a 00000000 00000000 00000000 09 08 0000102c
1 0b 0000102c 3 1 0a 00000000 00000000 0000000b 0a 09 0000000b
1 0c 00001030 0 1 0b a5a5a5a5 00000000 00000000 0a 0a a5a5a5a5
0 0c 00001030 0 1 0b a5a5a5a5 00000000 00000000 0b 0a a5a5a5a5
0 0d 00001034 2 0 00 00000000 00000000 00000000 0b 0b 00001038
1 0d 00001034 1 1 0c 00000000 ffffffff 00000000 0b 0c ffffffff
1 0c 00001038 0 1 0d 12345678 00000000 00000000 0c 0d 12345678
1 0d 0000103c 0 1 0e 87654321 00000000 00000000 0d 0e 87654321
1 0e fffffffc 2 1 04 00000000 00000000 00000000 0e 04 00000000
1 0f 00002000 3 0 10 00000000 00000000 0000c0de 04 0e 0000c0de
1 10 00002004 0 1 10 00000010 00000000 00000000 10 04 00000010
1 10 00002004 0 1 10 00000010 00000000 00000000 10 04 00000010
1 11 00002008 0 1 11 00000011 00000000 00000000 10 11 00000011
1 12 0000200c 1 1 12 00000000 00000012 00000000 11 12 00000012
1 13 00002010 2 1 13 00000000 00000000 00000000 12 13 00002014
1 14 00002014 3 1 14 00000000 00000000 00000014 13 14 00000014
1 15 00002018 0 1 15 00000015 00000000 00000000 14 15 00000015
1 16 0000201c 0 1 16 00000016 00000000 00000000 15 16 00000016
0 17 00002020 1 0 00 00000000 0badf00d 00000000 16 15 0badf00d
1 17 00002020 1 1 17 00000000 0badf00d 00000000 16 17 0badf00d
1 18 00002024 0 1 18 00000018 00000000 00000000 17 18 00000018
1 fd 00002028 0 1 19 00000019 00000000 00000000 18 19 00000019
1 fe 0000202c 0 1 1a 0000001a 00000000 00000000 19 1a 0000001a
1 ff 00002030 2 1 1b 00000000 00000000 00000000 1a 1b 00002034
1 00 00002034 0 1 1c 0000001c 00000000 00000000 1b 1c 0000001c
1 00 00002034 0 1 1c 0000001c 00000000 00000000 1c 1b 0000001c
1 01 00002038 3 1 1d 00000000 00000000 0000001d 1c 1d 0000001d
1 02 0000203c 0 1 1e 0000001e 00000000 00000000 1d 1e 0000001e
1 03 00002040 1 1 1f 00000000 0000001f 00000000 1e 1f 0000001f
0 03 00002044 0 0 00 00000000 00000000 00000000 1f 00 00000000
1 04 00002044 0 1 00 ffffffff 00000000 00000000 1f 00 ffffffff
1 05 00002048 0 1 01 00000101 00000000 00000000 00 01 00000101
1 05 00002048 0 1 01 00000101 00000000 00000000 01 00 00000101
0 05 0000204c 0 0 00 00000000 00000000 00000000 01 02 00000000
